/* code_builder/huffman_merger.sv */
`timescale 1ns/1ps
`include "huffman_params.svh"

module huffman_merger (
	input  logic                    clk,
	input  logic                    reset,
	input  huffman_pkg::count_vec_t sorted_counts,
	input  huffman_pkg::id_vec_t    sorted_ids,
	input  logic                    sort_done,
	output huffman_pkg::code_vec_t  codes,
	output huffman_pkg::len_vec_t   lens,
	output logic                    merge_done
);
	import huffman_pkg::*;

	logic                         busy;
	logic [2:0]                   n;   // active slots
	count_vec_t                   slot_w;
	sym_set_t [`NUM_SYMBOLS-1:0]  slot_set;
	count_vec_t                   nxt_w;
	count_vec_t                   w_down;
	sym_set_t [`NUM_SYMBOLS-1:0]  nxt_set;
	sym_set_t [`NUM_SYMBOLS-1:0]  set_down;
	code_vec_t                    nxt_codes;
	len_vec_t                     nxt_lens;
	logic [2:0]                   ia;
	logic [2:0]                   ib;
	logic [2:0]                   pos;
	logic                         found;
	count_t                       sum_w;
	sym_set_t                     sum_set;
	logic                         lens_ok;

	always_comb
	begin
		ia      = n - 3'd2;   // upper of the two lightest
		ib      = n - 3'd1;
		sum_w   = slot_w[ia] + slot_w[ib];
		sum_set = slot_set[ia] | slot_set[ib];
		w_down   = slot_w << `COUNT_W;     // element k holds old k-1
		set_down = slot_set << `NUM_SYMBOLS;

		pos   = ia;
		found = 1'b0;
		for (int k = 0; k < `NUM_SYMBOLS; k++)
		begin
			if (!found && (k < ia) && (slot_w[k] < sum_w))
			begin
				pos   = 3'(k);
				found = 1'b1;
			end
		end

		for (int k = 0; k < `NUM_SYMBOLS; k++)
		begin
			if (k < pos)
			begin
				nxt_w[k]   = slot_w[k];
				nxt_set[k] = slot_set[k];
			end
			else if (k == pos)
			begin
				nxt_w[k]   = sum_w;
				nxt_set[k] = sum_set;
			end
			else if (k <= ia)
			begin
				nxt_w[k]   = w_down[k];
				nxt_set[k] = set_down[k];
			end
			else
			begin
				nxt_w[k]   = '0;
				nxt_set[k] = '0;
			end
		end

		// new bit becomes the code msb
		nxt_codes = codes;
		nxt_lens  = lens;
		for (int j = 0; j < `NUM_SYMBOLS; j++)
		begin
			if (slot_set[ia][j] || slot_set[ib][j])
			begin
				nxt_codes[j][lens[j]] = slot_set[ib][j];
				nxt_lens[j]           = lens[j] + len_t'(1);
			end
		end

		lens_ok = 1'b1;
		for (int j = 0; j < `NUM_SYMBOLS; j++)
		begin
			if (lens[j] > len_t'(`MAX_CODE_LEN))
				lens_ok = 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy       <= 1'b0;
			n          <= 3'(`NUM_SYMBOLS);
			merge_done <= 1'b0;
		end
		else
		begin
			merge_done <= 1'b0;
			if (sort_done)
			begin
				busy <= 1'b1;
				n    <= 3'(`NUM_SYMBOLS);
			end
			else if (busy)
			begin
				n <= n - 3'd1;
				if (n == 3'd2)   // root formed
				begin
					busy       <= 1'b0;
					merge_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (sort_done)
		begin
			slot_w <= sorted_counts;
			for (int k = 0; k < `NUM_SYMBOLS; k++)
			begin
				slot_set[k] <= sym_set_t'(1) << (sorted_ids[k] - sym_id_t'(1));
			end
			codes <= '0;
			lens  <= '0;
		end
		else if (busy)
		begin
			slot_w   <= nxt_w;
			slot_set <= nxt_set;
			codes    <= nxt_codes;
			lens     <= nxt_lens;
		end
	end

	a_len_max: assert property (@(posedge clk) disable iff (reset)
		busy |=> lens_ok);

endmodule

/* code_builder/rank_sorter.sv */
`timescale 1ns/1ps
`include "huffman_params.svh"

module rank_sorter (
	input  logic                    clk,
	input  logic                    reset,
	input  huffman_pkg::count_vec_t counts,
	input  logic                    count_done,
	output huffman_pkg::count_vec_t sorted_counts,
	output huffman_pkg::id_vec_t    sorted_ids,
	output logic                    sort_done
);
	import huffman_pkg::*;

	logic       busy;
	logic [2:0] pass_cnt;
	logic       odd_pass;
	count_vec_t src_counts;
	count_vec_t nxt_counts;
	id_vec_t    init_ids;
	id_vec_t    src_ids;
	id_vec_t    nxt_ids;

	// the first even pass is applied while loading
	assign odd_pass = busy && pass_cnt[0];

	always_comb
	begin
		for (int k = 0; k < `NUM_SYMBOLS; k++)
		begin
			init_ids[k] = sym_id_t'(k + 1);
		end
		src_counts = busy ? sorted_counts : counts;
		src_ids    = busy ? sorted_ids : init_ids;
		nxt_counts = src_counts;
		nxt_ids    = src_ids;
		for (int k = 0; k < `NUM_SYMBOLS - 1; k++)
		begin
			// strict compare keeps ties in symbol order
			if (((k % 2) == int'(odd_pass)) && (src_counts[k+1] > src_counts[k]))
			begin
				nxt_counts[k]   = src_counts[k+1];
				nxt_counts[k+1] = src_counts[k];
				nxt_ids[k]      = src_ids[k+1];
				nxt_ids[k+1]    = src_ids[k];
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			pass_cnt  <= 3'd0;
			sort_done <= 1'b0;
		end
		else
		begin
			sort_done <= 1'b0;
			if (count_done)
			begin
				busy     <= 1'b1;
				pass_cnt <= 3'd1;
			end
			else if (busy)
			begin
				pass_cnt <= pass_cnt + 3'd1;
				if (pass_cnt == 3'(`SORT_PASSES - 1))   // last pass
				begin
					busy      <= 1'b0;
					sort_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (count_done || busy)
		begin
			sorted_counts <= nxt_counts;
			sorted_ids    <= nxt_ids;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		sort_done |=> !sort_done);

endmodule

/* common/huffman_params.svh */
`ifndef HUFFMAN_PARAMS_SVH
`define HUFFMAN_PARAMS_SVH

`define NUM_SYMBOLS  6
`define COUNT_W      8
`define CODE_W       8
`define LEN_W        3
`define MAX_CODE_LEN 5
`define SORT_PASSES  6
`define END_SYMBOL   0

`endif

/* common/huffman_pkg.sv */
`include "huffman_params.svh"

package huffman_pkg;

	typedef logic [7:0]              symbol_t;   // raw grey level
	typedef logic [`COUNT_W-1:0]     count_t;
	typedef logic [`CODE_W-1:0]      code_t;
	typedef logic [`LEN_W-1:0]       len_t;

	// bit i stands for symbol i+1
	typedef logic [`NUM_SYMBOLS-1:0] sym_set_t;

	typedef logic [2:0]              sym_id_t;   // 1 to 6

	typedef count_t  [`NUM_SYMBOLS-1:0] count_vec_t;
	typedef code_t   [`NUM_SYMBOLS-1:0] code_vec_t;
	typedef len_t    [`NUM_SYMBOLS-1:0] len_vec_t;
	typedef sym_id_t [`NUM_SYMBOLS-1:0] id_vec_t;

endpackage

/* dv/huffman_model.svh */
`ifndef HUFFMAN_MODEL_SVH
`define HUFFMAN_MODEL_SVH

// counts of symbols 1 to 6 up to the first terminator taken
function automatic count_vec_t count_frame(input logic [8:0] q[$]);
	count_vec_t c;
	logic       closed;
	int         sym;
	c      = '0;
	closed = 1'b0;
	foreach (q[i])
	begin
		sym = int'(q[i][7:0]);
		if (q[i][8] && !closed)
		begin
			if (sym == `END_SYMBOL)
				closed = 1'b1;
			else if (sym >= 1 && sym <= `NUM_SYMBOLS)
				c[sym - 1] = c[sym - 1] + count_t'(1);
		end
	end
	return c;
endfunction

// expected codes and masks indexed by symbol number minus one
function automatic void huffman_reference(input count_vec_t cnt, output code_vec_t code,
	output code_vec_t mask);
	int wt[`NUM_SYMBOLS];
	int members[`NUM_SYMBOLS];
	int len[`NUM_SYMBOLS];
	int n;
	int pos;
	int sum;
	int joined;
	int a;
	int b;
	code = '0;
	mask = '0;
	n    = 0;
	// insertion keeps equal counts in symbol order
	for (int s = 0; s < `NUM_SYMBOLS; s++)
	begin
		pos = n;
		while (pos > 0 && wt[pos - 1] < int'(cnt[s]))
		begin
			wt[pos]      = wt[pos - 1];
			members[pos] = members[pos - 1];
			pos--;
		end
		wt[pos]      = int'(cnt[s]);
		members[pos] = 1 << s;
		len[s]       = 0;
		n++;
	end
	while (n > 1)
	begin
		a = n - 2;
		b = n - 1;
		for (int s = 0; s < `NUM_SYMBOLS; s++)
		begin
			if (members[a][s])
				len[s]++;   // bit 0
			if (members[b][s])
			begin
				code[s] = code[s] | (code_t'(1) << len[s]);
				len[s]++;
			end
		end
		sum    = wt[a] + wt[b];
		joined = members[a] | members[b];
		n      = n - 2;
		pos    = 0;
		while (pos < n && wt[pos] >= sum)
			pos++;
		for (int k = n; k > pos; k--)
		begin
			wt[k]      = wt[k - 1];
			members[k] = members[k - 1];
		end
		wt[pos]      = sum;
		members[pos] = joined;
		n++;
	end
	for (int s = 0; s < `NUM_SYMBOLS; s++)
		mask[s] = code_t'((1 << len[s]) - 1);
endfunction

`endif

/* dv/huffman_tb.sv */
`timescale 1ns/1ps
`include "huffman_params.svh"

module huffman_tb;
	import huffman_pkg::*;

	localparam int CLK_PERIOD       = 8;
	localparam int NUM_TESTS        = 10;
	localparam int MAX_FRAME_CYCLES = 700;   // symbols, gaps, noise and tail beats
	localparam int CODE_LATENCY     = 13;

	logic       clk;
	logic       reset;
	logic       gray_valid;
	symbol_t    gray_data;
	logic       cnt_valid;
	logic       code_valid;
	count_t     cnt1, cnt2, cnt3, cnt4, cnt5, cnt6;
	code_t      hc1, hc2, hc3, hc4, hc5, hc6;
	code_t      m1, m2, m3, m4, m5, m6;
	count_vec_t dut_counts;
	code_vec_t  dut_hc;
	code_vec_t  dut_m;

	count_vec_t exp_counts;
	code_vec_t  exp_codes;
	code_vec_t  exp_masks;
	logic [8:0] beats[$];   // bit 8 is gray_valid
	int         target[`NUM_SYMBOLS];
	logic       armed = 1'b0;
	logic       prev_cnt_valid = 1'b0;
	logic       prev_code_valid = 1'b0;
	int         cycle_no = 0;
	int         cnt_cycle = 0;
	int         cnt_pulses = 0;
	int         code_rises = 0;
	int         check_count = 0;
	int         error_count = 0;
	int         tests_run = 0;
	int         failed_tests = 0;

	`include "huffman_model.svh"

	huffman_top i_huffman_top (.*);

	assign dut_counts = {cnt6, cnt5, cnt4, cnt3, cnt2, cnt1};
	assign dut_hc     = {hc6, hc5, hc4, hc3, hc2, hc1};
	assign dut_m      = {m6, m5, m4, m3, m2, m1};

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// outputs are sampled on the falling edge
	always @(negedge clk)
	begin
		cycle_no++;
		if (armed && !reset)
		begin
			if (cnt_valid && prev_cnt_valid)
			begin
				error_count++;
				$display("Error at %0d ns: cnt_valid stayed high for more than one cycle", $time);
			end
			if (cnt_valid && !prev_cnt_valid)
			begin
				cnt_pulses++;
				cnt_cycle = cycle_no;
			end
			if (cnt_pulses > 0)   // counts frozen once the frame closed
			begin
				for (int k = 0; k < `NUM_SYMBOLS; k++)
					check_value($sformatf("cnt%0d", k + 1), dut_counts[k], exp_counts[k]);
			end
			if (code_valid && !prev_code_valid)
			begin
				code_rises++;
				check_value("code_valid latency", cycle_no - cnt_cycle, CODE_LATENCY);
			end
			for (int k = 0; k < `NUM_SYMBOLS; k++)
			begin
				check_value($sformatf("hc%0d", k + 1), dut_hc[k], code_valid ? exp_codes[k] : '0);
				check_value($sformatf("m%0d", k + 1), dut_m[k], code_valid ? exp_masks[k] : '0);
			end
		end
		prev_cnt_valid  = cnt_valid;
		prev_code_valid = code_valid;
	end

	task automatic drive_beats();
		foreach (beats[i])
		begin
			@(posedge clk);
			#1;
			gray_valid = beats[i][8];
			gray_data  = beats[i][7:0];
		end
		@(posedge clk);
		#1;
		gray_valid = 1'b0;
	endtask

	task automatic apply_reset();
		armed = 1'b0;
		@(posedge clk);
		#1;
		reset      = 1'b1;
		gray_valid = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value("cnt_valid after reset", cnt_valid, 0);
		check_value("code_valid after reset", code_valid, 0);
		for (int k = 0; k < `NUM_SYMBOLS; k++)
		begin
			check_value($sformatf("cnt%0d after reset", k + 1), dut_counts[k], 0);
			check_value($sformatf("hc%0d after reset", k + 1), dut_hc[k], 0);
			check_value($sformatf("m%0d after reset", k + 1), dut_m[k], 0);
		end
		cnt_pulses = 0;
		code_rises = 0;
		cnt_cycle  = 0;
	endtask

	task automatic random_target(input int max_len);
		int len;
		int sym;
		target = '{default: 0};
		len    = 1 + int'($urandom % max_len);
		repeat (len)
		begin
			sym = int'($urandom % `NUM_SYMBOLS);
			target[sym]++;
		end
	endtask

	// shuffled frame with idle gaps, terminator, then a tail
	task automatic build_frame(input bit noise, input int tail_len);
		int pool[$];
		int idx;
		beats.delete();
		for (int s = 0; s < `NUM_SYMBOLS; s++)
			repeat (target[s]) pool.push_back(s + 1);
		while (pool.size() > 0)
		begin
			idx = int'($urandom % pool.size());
			if ($urandom % 4 == 0)
				beats.push_back({1'b0, 8'($urandom)});   // idle beat with junk data
			if (noise && ($urandom % 3 == 0))
				beats.push_back({1'b1, 8'(7 + $urandom % 249)});
			beats.push_back({1'b1, 8'(pool[idx])});
			pool.delete(idx);
		end
		beats.push_back({1'b1, 8'(`END_SYMBOL)});
		repeat (tail_len) beats.push_back({1'($urandom), 8'($urandom)});
	endtask

	task automatic run_test(input string name, input bit noise, input int tail_len,
		input int pre_len);
		int errors_before;
		int waited;
		errors_before = error_count;
		tests_run++;
		if (pre_len > 0)   // partial frame cut by the reset below
		begin
			apply_reset();
			beats.delete();
			repeat (pre_len) beats.push_back({1'b1, 8'(1 + $urandom % `NUM_SYMBOLS)});
			drive_beats();
		end
		apply_reset();
		build_frame(noise, tail_len);
		exp_counts = count_frame(beats);
		huffman_reference(exp_counts, exp_codes, exp_masks);
		armed = 1'b1;
		drive_beats();
		waited = 0;
		while (!code_valid && waited < 2 * CODE_LATENCY)
		begin
			@(negedge clk);
			waited++;
		end
		if (!code_valid)
		begin
			error_count++;
			$display("Error at %0d ns: code_valid never rose after the frame", $time);
		end
		repeat (8) @(negedge clk);   // results must hold
		check_value("cnt_valid pulses", cnt_pulses, 1);
		check_value("code_valid rises", code_rises, 1);
		if (error_count == errors_before)
			$display("Test %0d %s: ok", tests_run, name);
		else
		begin
			failed_tests++;
			$display("Test %0d %s: FAILED, %0d errors", tests_run, name,
				error_count - errors_before);
		end
	endtask

	initial
	begin
		void'($urandom(60));
		reset      = 1'b1;
		gray_valid = 1'b0;
		gray_data  = '0;
		random_target(200);
		run_test("random frame", 1'b0, 4, 0);
		target = '{12, 3, 30, 7, 1, 19};
		run_test("distinct counts", 1'b0, 4, 0);
		target = '{1, 2, 4, 8, 16, 32};
		run_test("skewed counts", 1'b0, 4, 0);
		target = '{5, 5, 5, 0, 5, 0};
		run_test("ties and zeros", 1'b0, 4, 0);
		target = '{7, 7, 7, 7, 7, 7};
		run_test("all equal", 1'b0, 4, 0);
		target = '{0, 0, 0, 0, 0, 0};
		run_test("empty frame", 1'b0, 4, 0);
		target = '{0, 0, 9, 0, 0, 0};
		run_test("single symbol", 1'b0, 4, 0);
		random_target(150);
		run_test("ignored input", 1'b1, 4, 0);
		target = '{4, 9, 2, 6, 11, 3};
		run_test("after terminator", 1'b0, 40, 0);
		target = '{3, 8, 8, 1, 0, 5};
		run_test("reset mid frame", 1'b0, 4, 30);
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_run, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * (MAX_FRAME_CYCLES + 40) * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles",
			NUM_TESTS * (MAX_FRAME_CYCLES + 40));
		$display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
+incdir+dv
common/huffman_pkg.sv
src/symbol_counter.sv
code_builder/rank_sorter.sv
code_builder/huffman_merger.sv
src/code_output.sv
src/huffman_top.sv
dv/huffman_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the huffman testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module huffman_tb \
	-o huffman_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/huffman_sim > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log && exit 0 || exit 1

/* src/code_output.sv */
`timescale 1ns/1ps
`include "huffman_params.svh"

module code_output (
	input  logic                   clk,
	input  logic                   reset,
	input  huffman_pkg::code_vec_t codes,
	input  huffman_pkg::len_vec_t  lens,
	input  logic                   merge_done,
	output logic                   code_valid,
	output huffman_pkg::code_vec_t hc_vec,
	output huffman_pkg::code_vec_t m_vec
);
	import huffman_pkg::*;

	code_vec_t masks;

	always_comb
	begin
		for (int j = 0; j < `NUM_SYMBOLS; j++)
		begin
			masks[j] = (code_t'(1) << lens[j]) - code_t'(1);   // lens low ones
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			code_valid <= 1'b0;
			hc_vec     <= '0;
			m_vec      <= '0;
		end
		else if (merge_done && !code_valid)
		begin
			hc_vec     <= codes;
			m_vec      <= masks;
			code_valid <= 1'b1;   // sticky until reset
		end
	end

	a_code_in_mask: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> ((hc_vec & ~m_vec) == '0));

endmodule

/* src/huffman_top.sv */
`timescale 1ns/1ps

module huffman_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 gray_valid,
	input  huffman_pkg::symbol_t gray_data,
	output logic                 cnt_valid,
	output huffman_pkg::count_t  cnt1,
	output huffman_pkg::count_t  cnt2,
	output huffman_pkg::count_t  cnt3,
	output huffman_pkg::count_t  cnt4,
	output huffman_pkg::count_t  cnt5,
	output huffman_pkg::count_t  cnt6,
	output logic                 code_valid,
	output huffman_pkg::code_t   hc1,
	output huffman_pkg::code_t   hc2,
	output huffman_pkg::code_t   hc3,
	output huffman_pkg::code_t   hc4,
	output huffman_pkg::code_t   hc5,
	output huffman_pkg::code_t   hc6,
	output huffman_pkg::code_t   m1,
	output huffman_pkg::code_t   m2,
	output huffman_pkg::code_t   m3,
	output huffman_pkg::code_t   m4,
	output huffman_pkg::code_t   m5,
	output huffman_pkg::code_t   m6
);
	import huffman_pkg::*;

	count_vec_t counts;
	logic       count_done;
	count_vec_t sorted_counts;
	id_vec_t    sorted_ids;
	logic       sort_done;
	code_vec_t  codes;
	len_vec_t   lens;
	logic       merge_done;
	code_vec_t  hc_vec;
	code_vec_t  m_vec;

	symbol_counter i_symbol_counter (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.counts     (counts),
		.count_done (count_done)
	);

	rank_sorter i_rank_sorter (
		.clk           (clk),
		.reset         (reset),
		.counts        (counts),
		.count_done    (count_done),
		.sorted_counts (sorted_counts),
		.sorted_ids    (sorted_ids),
		.sort_done     (sort_done)
	);

	huffman_merger i_huffman_merger (
		.clk           (clk),
		.reset         (reset),
		.sorted_counts (sorted_counts),
		.sorted_ids    (sorted_ids),
		.sort_done     (sort_done),
		.codes         (codes),
		.lens          (lens),
		.merge_done    (merge_done)
	);

	code_output i_code_output (
		.clk        (clk),
		.reset      (reset),
		.codes      (codes),
		.lens       (lens),
		.merge_done (merge_done),
		.code_valid (code_valid),
		.hc_vec     (hc_vec),
		.m_vec      (m_vec)
	);

	assign cnt_valid = count_done;
	assign cnt1 = counts[0];
	assign cnt2 = counts[1];
	assign cnt3 = counts[2];
	assign cnt4 = counts[3];
	assign cnt5 = counts[4];
	assign cnt6 = counts[5];

	assign hc1 = hc_vec[0];
	assign hc2 = hc_vec[1];
	assign hc3 = hc_vec[2];
	assign hc4 = hc_vec[3];
	assign hc5 = hc_vec[4];
	assign hc6 = hc_vec[5];

	assign m1 = m_vec[0];
	assign m2 = m_vec[1];
	assign m3 = m_vec[2];
	assign m4 = m_vec[3];
	assign m5 = m_vec[4];
	assign m6 = m_vec[5];

endmodule

/* src/symbol_counter.sv */
`timescale 1ns/1ps
`include "huffman_params.svh"

module symbol_counter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    gray_valid,
	input  huffman_pkg::symbol_t    gray_data,
	output huffman_pkg::count_vec_t counts,
	output logic                    count_done
);
	import huffman_pkg::*;

	logic       closed;   // frame already terminated
	logic       take;
	logic       is_end;
	logic       is_sym;
	logic [2:0] sym_idx;

	assign take    = gray_valid && !closed;
	assign is_end  = (gray_data == symbol_t'(`END_SYMBOL));
	assign is_sym  = (gray_data >= symbol_t'(1)) && (gray_data <= symbol_t'(`NUM_SYMBOLS));
	assign sym_idx = gray_data[2:0] - 3'd1;   // symbol 1 lands in slot 0

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			counts     <= '0;
			closed     <= 1'b0;
			count_done <= 1'b0;
		end
		else
		begin
			count_done <= 1'b0;
			if (take && is_end)
			begin
				closed     <= 1'b1;
				count_done <= 1'b1;
			end
			else if (take && is_sym)
			begin
				counts[sym_idx] <= counts[sym_idx] + count_t'(1);
			end
		end
	end

	// frames are limited to 255 symbols
	a_no_wrap: assert property (@(posedge clk) disable iff (reset)
		(take && is_sym) |-> (counts[sym_idx] != '1));

endmodule
